// File: hw/btac_config_pkg.sv
package btac_config_pkg;

  // every address in the cache is a full byte address.
  localparam int pc_width = 32;

  // direct-mapped target buffer.
  localparam int btb_entries = 32;
  localparam int btb_index_width = $clog2(btb_entries);

  // counter table, indexed one bit wider than the buffer.
  localparam int bht_entries = 64;
  localparam int bht_index_width = $clog2(bht_entries);

  // instructions are word aligned, so both indexes start at pc bit 2.
  localparam int index_lsb = 2;
  localparam int btb_index_msb = index_lsb + btb_index_width - 1;
  localparam int bht_index_msb = index_lsb + bht_index_width - 1;

  // 2-bit saturating counters; 1 is weakly not taken.
  localparam int counter_width = 2;
  localparam int counter_reset = 1;
  localparam int counter_max = 3;

  // step between sequential instructions.
  localparam int pc_step = 4;

endpackage

// File: hw/btac_types_pkg.sv
package btac_types_pkg;

  import btac_config_pkg::*;

  typedef logic [pc_width-1:0] pc_t;
  typedef logic [btb_index_width-1:0] btb_index_t;
  typedef logic [bht_index_width-1:0] bht_index_t;
  typedef logic [counter_width-1:0] counter_t;

  // one lookup presented by fetch.
  typedef struct packed {
    logic valid;
    pc_t pc;
  } fetch_req_t;

  // prediction returned to fetch one cycle after the lookup.
  typedef struct packed {
    logic valid;
    logic taken;
    pc_t baddr;
    pc_t taddr;
  } fetch_pred_t;

  // a branch resolved in execute, with the prediction it was fetched under.
  typedef struct packed {
    logic valid;
    pc_t pc;
    logic taken;
    pc_t target;
    logic pred_taken;
    pc_t pred_taddr;
  } resolve_req_t;

  // redirect back to fetch.
  typedef struct packed {
    logic miss;
    pc_t maddr;
  } resolve_rsp_t;

  typedef struct packed {
    logic wen;
    btb_index_t waddr;
    pc_t tag;
    pc_t target;
  } btb_write_t;

  typedef struct packed {
    logic valid;
    pc_t tag;
    pc_t target;
  } btb_entry_t;

  typedef struct packed {
    logic wen;
    bht_index_t index;
    logic taken;
  } bht_update_t;

endpackage

// File: hw/btb_store.sv
`timescale 1ns/1ps

module btb_store
  import btac_config_pkg::*, btac_types_pkg::*;
(
  input logic clock,
  input logic reset,
  input btb_write_t write,
  input btb_index_t raddr,
  output btb_entry_t rdata
);

  logic [btb_entries-1:0] valid;
  pc_t tag_array [btb_entries];
  pc_t target_array [btb_entries];

  // a cleared valid bit marks an entry as empty.
  always_ff @(posedge clock) begin
    if (!reset) begin
      valid <= '0;
    end else if (write.wen) begin
      valid[write.waddr] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (write.wen) begin
      tag_array[write.waddr] <= write.tag;
      target_array[write.waddr] <= write.target;
    end
  end

  // the read is combinational so lookup sees a write from the previous edge.
  assign rdata.valid = valid[raddr];
  assign rdata.tag = tag_array[raddr];
  assign rdata.target = target_array[raddr];

  // the write address comes from the registered resolve stage.
  assert property (@(posedge clock) disable iff (!reset)
    write.wen |-> !$isunknown(write.waddr))
    else $error("btb write address is unknown");

endmodule

// File: hw/bht_store.sv
`timescale 1ns/1ps

module bht_store
  import btac_config_pkg::*, btac_types_pkg::*;
(
  input logic clock,
  input logic reset,
  input bht_update_t update,
  input bht_index_t raddr,
  output counter_t rdata
);

  counter_t counters [bht_entries];
  counter_t current;
  counter_t next_count;

  // saturating step of the counter selected by the update port.
  always_comb begin
    current = counters[update.index];
    next_count = current;
    if (update.taken && current != counter_t'(counter_max)) begin
      next_count = current + 1'b1;
    end else if (!update.taken && current != '0) begin
      next_count = current - 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < bht_entries; i++) begin
        counters[i] <= counter_t'(counter_reset);
      end
    end else if (update.wen) begin
      counters[update.index] <= next_count;
    end
  end

  assign rdata = counters[raddr];

  // a taken update never wraps past counter_max and a not-taken one never wraps below zero.
  assert property (@(posedge clock) disable iff (!reset)
    update.wen |-> (update.taken ? next_count >= current : next_count <= current))
    else $error("bht counter update wrapped around");

endmodule

// File: hw/btac_resolve.sv
`timescale 1ns/1ps

module btac_resolve
  import btac_config_pkg::*, btac_types_pkg::*;
(
  input logic clock,
  input logic reset,
  input logic clear,
  input resolve_req_t req,
  output resolve_rsp_t rsp,
  output btb_write_t btb_write,
  output bht_update_t bht_update
);

  logic valid_q;
  resolve_req_t req_q;
  logic dir_miss;
  logic target_miss;
  pc_t fallthrough;

  // a flush drops the resolve, so nothing is trained from it.
  always_ff @(posedge clock) begin
    if (!reset || clear) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req.valid;
    end
  end

  always_ff @(posedge clock) begin
    req_q <= req;
  end

  // a taken branch predicted taken still misses when the target was wrong.
  assign dir_miss = req_q.taken != req_q.pred_taken;
  assign target_miss = req_q.taken && req_q.pred_taken &&
                       (req_q.target != req_q.pred_taddr);
  assign fallthrough = req_q.pc + pc_t'(pc_step);

  always_comb begin
    rsp = '0;
    if (valid_q) begin
      rsp.miss = dir_miss || target_miss;
      rsp.maddr = req_q.taken ? req_q.target : fallthrough;
    end
  end

  // only taken branches allocate a target; not-taken ones leave the entry alone.
  assign btb_write.wen = valid_q && req_q.taken;
  assign btb_write.waddr = req_q.pc[btb_index_msb:index_lsb];
  assign btb_write.tag = req_q.pc;
  assign btb_write.target = req_q.target;

  assign bht_update.wen = valid_q;
  assign bht_update.index = req_q.pc[bht_index_msb:index_lsb];
  assign bht_update.taken = req_q.taken;

  assert property (@(posedge clock) disable iff (!reset)
    rsp.miss |-> $past(req.valid && !clear))
    else $error("resolve miss without an accepted request");

endmodule

// File: hw/btac_lookup.sv
`timescale 1ns/1ps

module btac_lookup
  import btac_config_pkg::*, btac_types_pkg::*;
(
  input logic clock,
  input logic reset,
  input logic clear,
  input fetch_req_t req,
  output fetch_pred_t pred,
  output btb_index_t btb_raddr,
  input btb_entry_t btb_rdata,
  output bht_index_t bht_raddr,
  input counter_t bht_rdata
);

  logic valid_q;
  pc_t pc_q;
  logic hit;

  always_ff @(posedge clock) begin
    if (!reset || clear) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req.valid;
    end
  end

  always_ff @(posedge clock) begin
    pc_q <= req.pc;
  end

  // both tables are read from the registered pc, so a training write at
  // the same edge is already visible here.
  assign btb_raddr = pc_q[btb_index_msb:index_lsb];
  assign bht_raddr = pc_q[bht_index_msb:index_lsb];

  // the full pc is the tag, so aliasing pcs never hit each other's entry.
  assign hit = valid_q && btb_rdata.valid && (btb_rdata.tag == pc_q);

  always_comb begin
    pred = '0;
    if (valid_q) begin
      pred.valid = 1'b1;
      pred.taken = hit && bht_rdata[counter_width-1];
      pred.baddr = pc_q;
      pred.taddr = hit ? btb_rdata.target : '0;
    end
  end

  assert property (@(posedge clock) disable iff (!reset)
    pred.taken |-> pred.valid && $past(req.valid && !clear))
    else $error("taken prediction without an accepted lookup");

endmodule

// File: hw/btac.sv
`timescale 1ns/1ps

module btac
  import btac_types_pkg::*;
(
  input logic clock,
  input logic reset,
  input logic clear,
  input fetch_req_t fetch_req,
  output fetch_pred_t fetch_pred,
  input resolve_req_t resolve_req,
  output resolve_rsp_t resolve_rsp
);

  btb_write_t btb_write;
  bht_update_t bht_update;
  btb_index_t btb_raddr;
  btb_entry_t btb_rdata;
  bht_index_t bht_raddr;
  counter_t bht_rdata;

  btac_resolve resolve_stage (
    .clock (clock),
    .reset (reset),
    .clear (clear),
    .req (resolve_req),
    .rsp (resolve_rsp),
    .btb_write (btb_write),
    .bht_update (bht_update)
  );

  btb_store btb (
    .clock (clock),
    .reset (reset),
    .write (btb_write),
    .raddr (btb_raddr),
    .rdata (btb_rdata)
  );

  bht_store bht (
    .clock (clock),
    .reset (reset),
    .update (bht_update),
    .raddr (bht_raddr),
    .rdata (bht_rdata)
  );

  btac_lookup lookup_stage (
    .clock (clock),
    .reset (reset),
    .clear (clear),
    .req (fetch_req),
    .pred (fetch_pred),
    .btb_raddr (btb_raddr),
    .btb_rdata (btb_rdata),
    .bht_raddr (bht_raddr),
    .bht_rdata (bht_rdata)
  );

endmodule

// File: tb/btac_tb_table.svh
localparam int num_steps = 26;

// each row holds test, kind, pc, taken, target, pred_taken, pred_taddr and flag.
// flag is the expected taken for a lookup and the expected miss for a resolve.
step_t step_table [num_steps] = '{
  // cold tables after reset.
  '{4'd1, kind_idle,    32'h0000_0000, 1'b0, 32'h0000_0000, 1'b0, 32'h0000_0000, 1'b0},
  '{4'd1, kind_lookup,  32'h0000_0100, 1'b0, 32'h0000_0000, 1'b0, 32'h0000_0000, 1'b0},
  '{4'd1, kind_lookup,  32'h0000_0204, 1'b0, 32'h0000_0000, 1'b0, 32'h0000_0000, 1'b0},
  '{4'd1, kind_lookup,  32'h0000_1040, 1'b0, 32'h0000_0000, 1'b0, 32'h0000_0000, 1'b0},
  '{4'd1, kind_lookup,  32'h0000_03f8, 1'b0, 32'h0000_0000, 1'b0, 32'h0000_0000, 1'b0},

  // first taken resolve allocates the entry and moves the counter to 2.
  '{4'd2, kind_resolve, 32'h0000_1040, 1'b1, 32'h0000_2000, 1'b0, 32'h0000_0000, 1'b1},
  '{4'd2, kind_lookup,  32'h0000_1040, 1'b0, 32'h0000_0000, 1'b0, 32'h0000_0000, 1'b1},

  // the counter saturates at 3, then two not-taken resolves bring it down to 1.
  '{4'd3, kind_resolve, 32'h0000_1040, 1'b1, 32'h0000_2000, 1'b1, 32'h0000_2000, 1'b0},
  '{4'd3, kind_resolve, 32'h0000_1040, 1'b1, 32'h0000_2000, 1'b1, 32'h0000_2000, 1'b0},
  '{4'd3, kind_lookup,  32'h0000_1040, 1'b0, 32'h0000_0000, 1'b0, 32'h0000_0000, 1'b1},
  '{4'd3, kind_resolve, 32'h0000_1040, 1'b0, 32'h0000_2000, 1'b1, 32'h0000_2000, 1'b1},
  '{4'd3, kind_lookup,  32'h0000_1040, 1'b0, 32'h0000_0000, 1'b0, 32'h0000_0000, 1'b1},
  '{4'd3, kind_resolve, 32'h0000_1040, 1'b0, 32'h0000_2000, 1'b1, 32'h0000_2000, 1'b1},
  '{4'd3, kind_lookup,  32'h0000_1040, 1'b0, 32'h0000_0000, 1'b0, 32'h0000_0000, 1'b0},

  // correct predictions, then a wrong target that rewrites the entry.
  '{4'd4, kind_resolve, 32'h0000_1040, 1'b0, 32'h0000_0000, 1'b0, 32'h0000_0000, 1'b0},
  '{4'd4, kind_resolve, 32'h0000_1040, 1'b1, 32'h0000_2000, 1'b1, 32'h0000_2000, 1'b0},
  '{4'd4, kind_lookup,  32'h0000_1040, 1'b0, 32'h0000_0000, 1'b0, 32'h0000_0000, 1'b0},
  '{4'd4, kind_resolve, 32'h0000_1040, 1'b1, 32'h0000_3000, 1'b1, 32'h0000_2000, 1'b1},
  '{4'd4, kind_lookup,  32'h0000_1040, 1'b0, 32'h0000_0000, 1'b0, 32'h0000_0000, 1'b1},

  // 0x10c0 shares the buffer index of 0x1040 but has its own counter.
  '{4'd5, kind_lookup,  32'h0000_10c0, 1'b0, 32'h0000_0000, 1'b0, 32'h0000_0000, 1'b0},
  '{4'd5, kind_resolve, 32'h0000_10c0, 1'b1, 32'h0000_4000, 1'b0, 32'h0000_0000, 1'b1},
  '{4'd5, kind_lookup,  32'h0000_10c0, 1'b0, 32'h0000_0000, 1'b0, 32'h0000_0000, 1'b1},
  '{4'd5, kind_lookup,  32'h0000_1040, 1'b0, 32'h0000_0000, 1'b0, 32'h0000_0000, 1'b0},

  // the flushed not-taken resolve would otherwise turn the prediction off.
  '{4'd6, kind_clear,   32'h0000_10c0, 1'b0, 32'h0000_0000, 1'b1, 32'h0000_4000, 1'b0},
  '{4'd6, kind_lookup,  32'h0000_10c0, 1'b0, 32'h0000_0000, 1'b0, 32'h0000_0000, 1'b1},
  '{4'd6, kind_idle,    32'h0000_0000, 1'b0, 32'h0000_0000, 1'b0, 32'h0000_0000, 1'b0}
};

// File: tb/btac_tb.sv
`timescale 1ns/1ps

module btac_tb
  import btac_config_pkg::*, btac_types_pkg::*;
();

  typedef enum logic [1:0] {kind_idle, kind_lookup, kind_resolve, kind_clear} step_kind_t;

  typedef struct packed {
    logic [3:0] test;
    step_kind_t kind;
    pc_t pc;
    logic taken;
    pc_t target;
    logic pred_taken;
    pc_t pred_taddr;
    logic flag;
  } step_t;

  `include "btac_tb_table.svh"

  localparam int reset_timeout = 20;

  logic clock;
  logic reset;
  logic clear;
  fetch_req_t fetch_req;
  fetch_pred_t fetch_pred;
  resolve_req_t resolve_req;
  resolve_rsp_t resolve_rsp;

  // reference copy of both tables.
  logic ref_valid [btb_entries];
  pc_t ref_tag [btb_entries];
  pc_t ref_target [btb_entries];
  int ref_count [bht_entries];

  int checks = 0;
  int errors = 0;
  int test_errors = 0;
  int tests_run = 0;
  int tests_failed = 0;

  btac dut (
    .clock (clock),
    .reset (reset),
    .clear (clear),
    .fetch_req (fetch_req),
    .fetch_pred (fetch_pred),
    .resolve_req (resolve_req),
    .resolve_rsp (resolve_rsp)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  initial begin
    reset = 1'b0;
    repeat (2) @(posedge clock);
    reset <= 1'b1;
  end

  function automatic string test_name(int test);
    case (test)
      1: return "cold lookups";
      2: return "training";
      3: return "saturation and detraining";
      4: return "correct and wrong-target predictions";
      5: return "aliasing";
      default: return "clear";
    endcase
  endfunction

  task automatic clear_model();
    for (int i = 0; i < btb_entries; i++) begin
      ref_valid[i] = 1'b0;
      ref_tag[i] = '0;
      ref_target[i] = '0;
    end
    for (int i = 0; i < bht_entries; i++) begin
      ref_count[i] = counter_reset;
    end
  endtask

  function automatic fetch_pred_t expected_pred(step_t s);
    fetch_pred_t p;
    btb_index_t bi;
    bht_index_t hi;
    logic hit;
    p = '0;
    bi = s.pc[btb_index_msb:index_lsb];
    hi = s.pc[bht_index_msb:index_lsb];
    hit = ref_valid[bi] && (ref_tag[bi] == s.pc);
    if (s.kind == kind_lookup) begin
      p.valid = 1'b1;
      p.taken = hit && (ref_count[hi] >= 2);
      p.baddr = s.pc;
      p.taddr = hit ? ref_target[bi] : '0;
    end
    return p;
  endfunction

  function automatic resolve_rsp_t expected_rsp(step_t s);
    resolve_rsp_t r;
    r = '0;
    if (s.kind == kind_resolve) begin
      r.miss = (s.taken != s.pred_taken) ||
               (s.taken && s.pred_taken && (s.target != s.pred_taddr));
      r.maddr = s.taken ? s.target : s.pc + 32'd4;
    end
    return r;
  endfunction

  // a trained branch moves its counter one step and, when taken, owns its entry.
  task automatic train_model(step_t s);
    btb_index_t bi;
    bht_index_t hi;
    bi = s.pc[btb_index_msb:index_lsb];
    hi = s.pc[bht_index_msb:index_lsb];
    if (s.taken) begin
      ref_valid[bi] = 1'b1;
      ref_tag[bi] = s.pc;
      ref_target[bi] = s.target;
      if (ref_count[hi] < counter_max) ref_count[hi]++;
    end else if (ref_count[hi] > 0) begin
      ref_count[hi]--;
    end
  endtask

  task automatic drive_step(step_t s);
    fetch_req_t f;
    resolve_req_t r;
    f = '0;
    r = '0;
    if (s.kind == kind_lookup || s.kind == kind_clear) begin
      f.valid = 1'b1;
      f.pc = s.pc;
    end
    if (s.kind == kind_resolve || s.kind == kind_clear) begin
      r.valid = 1'b1;
      r.pc = s.pc;
      r.taken = s.taken;
      r.target = s.target;
      r.pred_taken = s.pred_taken;
      r.pred_taddr = s.pred_taddr;
    end
    fetch_req <= f;
    resolve_req <= r;
    clear <= (s.kind == kind_clear);
  endtask

  task automatic check_value(int step, string name, pc_t expected, pc_t actual);
    checks++;
    assert (actual === expected) else begin
      $display("[ERROR] step %0d %s expected 0x%h actual 0x%h", step, name, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_step(int step, step_t s);
    fetch_pred_t p;
    resolve_rsp_t r;
    logic model_flag;
    p = expected_pred(s);
    r = expected_rsp(s);
    model_flag = (s.kind == kind_resolve) ? r.miss : p.taken;
    checks++;
    assert (model_flag == s.flag) else begin
      $display("step %0d: the reference model disagrees with the table's expected flag", step);
      errors++;
      test_errors++;
    end
    check_value(step, "fetch_pred.valid", pc_t'(p.valid), pc_t'(fetch_pred.valid));
    check_value(step, "fetch_pred.taken", pc_t'(p.taken), pc_t'(fetch_pred.taken));
    check_value(step, "fetch_pred.baddr", p.baddr, fetch_pred.baddr);
    check_value(step, "fetch_pred.taddr", p.taddr, fetch_pred.taddr);
    check_value(step, "resolve_rsp.miss", pc_t'(r.miss), pc_t'(resolve_rsp.miss));
    check_value(step, "resolve_rsp.maddr", r.maddr, resolve_rsp.maddr);
  endtask

  initial begin
    int waited;
    logic timed_out;
    logic last_of_test;
    fetch_req = '0;
    resolve_req = '0;
    clear = 1'b0;
    clear_model();
    waited = 0;
    timed_out = 1'b0;
    while (reset !== 1'b1 && !timed_out) begin
      @(posedge clock);
      waited++;
      if (waited > reset_timeout) timed_out = 1'b1;
    end
    if (timed_out) begin
      $display("reset was not released within %0d cycles", reset_timeout);
      $display("Testbench failed");
      $finish;
    end else begin
      for (int i = 0; i < num_steps; i++) begin
        @(posedge clock);
        drive_step(step_table[i]);
        @(posedge clock);
        drive_step('0);
        @(negedge clock);
        check_step(i, step_table[i]);
        if (step_table[i].kind == kind_resolve) train_model(step_table[i]);
        if (i == num_steps - 1) begin
          last_of_test = 1'b1;
        end else begin
          last_of_test = step_table[i + 1].test != step_table[i].test;
        end
        if (last_of_test) begin
          tests_run++;
          if (test_errors != 0) tests_failed++;
          $display("test %0d %s: %s, %0d errors", step_table[i].test,
                   test_name(int'(step_table[i].test)),
                   (test_errors == 0) ? "ok" : "wrong", test_errors);
          test_errors = 0;
        end
      end
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
        $display("Testbench passed");
      end else begin
        $display("Testbench failed");
      end
      $finish;
    end
  end

endmodule

// File: project.f
+incdir+tb
hw/btac_config_pkg.sv
hw/btac_types_pkg.sv
hw/btb_store.sv
hw/bht_store.sv
hw/btac_resolve.sv
hw/btac_lookup.sv
hw/btac.sv
tb/btac_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module btac_tb -Mdir obj_dir -f project.f

./obj_dir/Vbtac_tb 2>&1 | tee sim.log

if grep -q "Testbench failed" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
  echo "simulation ended without a result, see sim.log"
  exit 1
fi
exit 0
